// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

  // ------------------------------
  // Port and ID widths
  // ------------------------------
  localparam int NumPorts    = 2;
  localparam int PortIdWidth = 2;
  // One extra bit carries the initiator port number
  localparam int TagIdWidth  = PortIdWidth + 1;
  localparam int MemIdWidth  = 1;
  localparam int NumSlots    = 2;

  typedef logic [31:0]            addr_t;
  typedef logic [31:0]            data_t;
  typedef logic [PortIdWidth-1:0] port_id_t;
  typedef logic [MemIdWidth-1:0]  mem_id_t;

  // ------------------------------
  // Clock domain crossing
  // ------------------------------
  localparam int LogDepth = 1;

  typedef logic [LogDepth:0] ptr_t;

  // Full when the write pointer equals the read pointer with the top two bits inverted
  localparam ptr_t PtrFullMask = ptr_t'(2'b11) << (LogDepth - 1);

  // Request entry {addr, wdata, we, id}, memory ID in the low bits
  localparam int ReqBits = $bits(addr_t) + $bits(data_t) + 1 + MemIdWidth;
  // Response entry {rdata, err, id}
  localparam int RspBits = $bits(data_t) + 1 + MemIdWidth;

  typedef logic [ReqBits-1:0] req_entry_t;
  typedef logic [RspBits-1:0] rsp_entry_t;

  // Entry i sits at bits [i*Bits +: Bits]
  typedef logic [(2**LogDepth)*ReqBits-1:0] req_fifo_t;
  typedef logic [(2**LogDepth)*RspBits-1:0] rsp_fifo_t;

endpackage

// ==== mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if
  import mem_bus_pkg::*;
#(
  parameter int IdWidth = 1
) ();

  // Request channel
  logic               req_valid;
  logic               req_ready;
  addr_t              req_addr;
  data_t              req_wdata;
  logic               req_we;
  logic [IdWidth-1:0] req_id;

  // Response channel
  logic               rsp_valid;
  logic               rsp_ready;
  data_t              rsp_rdata;
  logic               rsp_err;
  logic [IdWidth-1:0] rsp_id;

  modport initiator (
    output req_valid, req_addr, req_wdata, req_we, req_id, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata, rsp_err, rsp_id
  );

  modport target (
    input  req_valid, req_addr, req_wdata, req_we, req_id, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata, rsp_err, rsp_id
  );

endinterface

// ==== port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter
  import mem_bus_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic     [NumPorts-1:0] req_valid_i,
  input  logic     [NumPorts-1:0] req_we_i,
  input  addr_t    [NumPorts-1:0] req_addr_i,
  input  data_t    [NumPorts-1:0] req_wdata_i,
  input  port_id_t [NumPorts-1:0] req_id_i,
  output logic     [NumPorts-1:0] req_ready_o,
  output logic     [NumPorts-1:0] rsp_valid_o,
  output logic     [NumPorts-1:0] rsp_err_o,
  output data_t    [NumPorts-1:0] rsp_rdata_o,
  output port_id_t [NumPorts-1:0] rsp_id_o,
  input  logic     [NumPorts-1:0] rsp_ready_i,
  mem_bus_if.initiator            mst
);

  logic prio_q;
  logic lock_q;
  logic lock_idx_q;
  logic gnt_idx;
  logic rsp_port;

  // ------------------------------
  // Request merge
  // ------------------------------
  // A stalled grant stays put so the outgoing payload does not change
  always_comb begin
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end else if (&req_valid_i) begin
      gnt_idx = prio_q;
    end else begin
      gnt_idx = req_valid_i[1];
    end
  end

  assign mst.req_valid = req_valid_i[gnt_idx];
  assign mst.req_addr  = req_addr_i[gnt_idx];
  assign mst.req_wdata = req_wdata_i[gnt_idx];
  assign mst.req_we    = req_we_i[gnt_idx];
  // Port number goes on top of the initiator ID
  assign mst.req_id    = {gnt_idx, req_id_i[gnt_idx]};

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      req_ready_o[i] = mst.req_ready && (gnt_idx == 1'(i));
    end
  end

  // Other port gets priority after every granted transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else if (mst.req_valid && mst.req_ready) begin
      prio_q <= !gnt_idx;
      lock_q <= 1'b0;
    end else if (mst.req_valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

  // ------------------------------
  // Response routing
  // ------------------------------
  assign rsp_port      = mst.rsp_id[TagIdWidth-1];
  assign mst.rsp_ready = rsp_ready_i[rsp_port];

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      rsp_valid_o[i] = mst.rsp_valid && (rsp_port == 1'(i));
      rsp_err_o[i]   = mst.rsp_err;
      rsp_rdata_o[i] = mst.rsp_rdata;
      rsp_id_o[i]    = mst.rsp_id[PortIdWidth-1:0];
    end
  end

endmodule

// ==== bus_cut.sv ====
`timescale 1ns/1ps

module bus_cut
  import mem_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  mem_bus_if.target    slv,
  mem_bus_if.initiator mst
);

  logic                  alive_q;
  logic                  req_valid_q;
  addr_t                 req_addr_q;
  data_t                 req_wdata_q;
  logic                  req_we_q;
  logic [TagIdWidth-1:0] req_id_q;
  logic                  rsp_valid_q;
  data_t                 rsp_rdata_q;
  logic                  rsp_err_q;
  logic [TagIdWidth-1:0] rsp_id_q;

  // Take a new item when empty or when the held one leaves this cycle
  assign slv.req_ready = alive_q && (!req_valid_q || mst.req_ready);
  assign mst.rsp_ready = alive_q && (!rsp_valid_q || slv.rsp_ready);

  assign mst.req_valid = req_valid_q;
  assign mst.req_addr  = req_addr_q;
  assign mst.req_wdata = req_wdata_q;
  assign mst.req_we    = req_we_q;
  assign mst.req_id    = req_id_q;

  assign slv.rsp_valid = rsp_valid_q;
  assign slv.rsp_rdata = rsp_rdata_q;
  assign slv.rsp_err   = rsp_err_q;
  assign slv.rsp_id    = rsp_id_q;

  // Ready stays low until the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alive_q     <= 1'b0;
      req_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      alive_q <= 1'b1;
      if (slv.req_ready) begin
        req_valid_q <= slv.req_valid;
      end
      if (mst.rsp_ready) begin
        rsp_valid_q <= mst.rsp_valid;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv.req_valid && slv.req_ready) begin
      req_addr_q  <= slv.req_addr;
      req_wdata_q <= slv.req_wdata;
      req_we_q    <= slv.req_we;
      req_id_q    <= slv.req_id;
    end
    if (mst.rsp_valid && mst.rsp_ready) begin
      rsp_rdata_q <= mst.rsp_rdata;
      rsp_err_q   <= mst.rsp_err;
      rsp_id_q    <= mst.rsp_id;
    end
  end

endmodule

// ==== id_remap.sv ====
`timescale 1ns/1ps

module id_remap
  import mem_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  mem_bus_if.target    slv,
  mem_bus_if.initiator mst
);

  logic [NumSlots-1:0]   busy_q;
  logic [TagIdWidth-1:0] slot_id_q [NumSlots];
  logic                  any_free;
  mem_id_t               free_idx;
  logic                  hold_q;
  mem_id_t               hold_slot_q;
  mem_id_t               req_slot;
  logic                  req_fire;
  logic                  rsp_fire;

  // ------------------------------
  // Slot allocation
  // ------------------------------
  // Lowest free slot wins
  always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        any_free = 1'b1;
        free_idx = mem_id_t'(i);
      end
    end
  end

  // Keep the slot of a stalled request so its ID stays stable
  assign req_slot = hold_q ? hold_slot_q : free_idx;

  assign mst.req_valid = slv.req_valid && any_free;
  assign slv.req_ready = mst.req_ready && any_free;
  assign mst.req_addr  = slv.req_addr;
  assign mst.req_wdata = slv.req_wdata;
  assign mst.req_we    = slv.req_we;
  assign mst.req_id    = req_slot;

  assign req_fire = mst.req_valid && mst.req_ready;
  assign rsp_fire = mst.rsp_valid && mst.rsp_ready;

  // ------------------------------
  // Response restore
  // ------------------------------
  assign slv.rsp_valid = mst.rsp_valid;
  assign slv.rsp_rdata = mst.rsp_rdata;
  assign slv.rsp_err   = mst.rsp_err;
  assign slv.rsp_id    = slot_id_q[mst.rsp_id];
  assign mst.rsp_ready = slv.rsp_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q      <= '0;
      hold_q      <= 1'b0;
      hold_slot_q <= '0;
    end else begin
      // Freed and claimed slots never coincide
      if (rsp_fire) begin
        busy_q[mst.rsp_id] <= 1'b0;
      end
      if (req_fire) begin
        busy_q[req_slot] <= 1'b1;
        hold_q           <= 1'b0;
      end else if (mst.req_valid) begin
        hold_q      <= 1'b1;
        hold_slot_q <= req_slot;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      slot_id_q[req_slot] <= slv.req_id;
    end
  end

endmodule

// ==== cdc_gray_src.sv ====
`timescale 1ns/1ps

module cdc_gray_src
  import mem_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  mem_bus_if.target slv,
  output ptr_t      req_wptr_o,
  output req_fifo_t req_fifo_o,
  input  ptr_t      req_rptr_i,
  input  ptr_t      rsp_wptr_i,
  input  rsp_fifo_t rsp_fifo_i,
  output ptr_t      rsp_rptr_o
);

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  ptr_t                            req_wbin_q;
  ptr_t                            req_wgray_q;
  ptr_t                            req_wbin_next;
  ptr_t                            req_rptr_s1_q;
  ptr_t                            req_rptr_s2_q;
  req_entry_t [2**LogDepth-1:0]    req_mem_q;
  req_entry_t                      req_entry;
  logic                            req_full;
  logic                            req_push;

  ptr_t                            rsp_rbin_q;
  ptr_t                            rsp_rgray_q;
  ptr_t                            rsp_rbin_next;
  ptr_t                            rsp_wptr_s1_q;
  ptr_t                            rsp_wptr_s2_q;
  rsp_entry_t [2**LogDepth-1:0]    rsp_entries;
  rsp_entry_t                      rsp_head;
  logic                            rsp_pop;

  // ------------------------------
  // Request half
  // ------------------------------
  assign req_full      = (req_wgray_q == (req_rptr_s2_q ^ PtrFullMask));
  assign slv.req_ready = !req_full;
  assign req_push      = slv.req_valid && slv.req_ready;
  assign req_wbin_next = req_wbin_q + 1'b1;
  assign req_entry     = {slv.req_addr, slv.req_wdata, slv.req_we, slv.req_id};

  assign req_wptr_o = req_wgray_q;
  assign req_fifo_o = req_mem_q;

  // Entry is written on the same edge that moves the pointer
  always_ff @(posedge clk_i) begin
    if (req_push) begin
      req_mem_q[req_wbin_q[LogDepth-1:0]] <= req_entry;
    end
  end

  // ------------------------------
  // Response half
  // ------------------------------
  assign rsp_entries   = rsp_fifo_i;
  assign rsp_head      = rsp_entries[rsp_rbin_q[LogDepth-1:0]];
  assign slv.rsp_valid = (rsp_wptr_s2_q != rsp_rgray_q);
  assign {slv.rsp_rdata, slv.rsp_err, slv.rsp_id} = rsp_head;
  assign rsp_pop       = slv.rsp_valid && slv.rsp_ready;
  assign rsp_rbin_next = rsp_rbin_q + 1'b1;

  assign rsp_rptr_o = rsp_rgray_q;

  // Pointers and two-flop synchronizers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_wbin_q    <= '0;
      req_wgray_q   <= '0;
      req_rptr_s1_q <= '0;
      req_rptr_s2_q <= '0;
      rsp_rbin_q    <= '0;
      rsp_rgray_q   <= '0;
      rsp_wptr_s1_q <= '0;
      rsp_wptr_s2_q <= '0;
    end else begin
      req_rptr_s1_q <= req_rptr_i;
      req_rptr_s2_q <= req_rptr_s1_q;
      rsp_wptr_s1_q <= rsp_wptr_i;
      rsp_wptr_s2_q <= rsp_wptr_s1_q;
      if (req_push) begin
        req_wbin_q  <= req_wbin_next;
        req_wgray_q <= bin2gray(req_wbin_next);
      end
      if (rsp_pop) begin
        rsp_rbin_q  <= rsp_rbin_next;
        rsp_rgray_q <= bin2gray(rsp_rbin_next);
      end
    end
  end

endmodule

// ==== cluster_mem_wrap.sv ====
`timescale 1ns/1ps

module cluster_mem_wrap
  import mem_bus_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Initiator ports
  input  logic     [NumPorts-1:0] req_valid_i,
  input  logic     [NumPorts-1:0] req_we_i,
  input  addr_t    [NumPorts-1:0] req_addr_i,
  input  data_t    [NumPorts-1:0] req_wdata_i,
  input  port_id_t [NumPorts-1:0] req_id_i,
  output logic     [NumPorts-1:0] req_ready_o,
  output logic     [NumPorts-1:0] rsp_valid_o,
  output logic     [NumPorts-1:0] rsp_err_o,
  output data_t    [NumPorts-1:0] rsp_rdata_o,
  output port_id_t [NumPorts-1:0] rsp_id_o,
  input  logic     [NumPorts-1:0] rsp_ready_i,
  // Memory side crossing
  output ptr_t                    req_wptr_o,
  output req_fifo_t               req_fifo_o,
  input  ptr_t                    req_rptr_i,
  input  ptr_t                    rsp_wptr_i,
  input  rsp_fifo_t               rsp_fifo_i,
  output ptr_t                    rsp_rptr_o
);

  mem_bus_if #(.IdWidth(TagIdWidth)) tag_bus ();
  mem_bus_if #(.IdWidth(TagIdWidth)) cut_bus ();
  mem_bus_if #(.IdWidth(MemIdWidth)) mem_bus ();

  port_arbiter i_port_arbiter (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_valid_i ( req_valid_i ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_id_i    ( req_id_i    ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_ready_i ( rsp_ready_i ),
    .mst         ( tag_bus     )
  );

  // Register stage between arbiter and remapper
  bus_cut i_bus_cut (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .slv     ( tag_bus ),
    .mst     ( cut_bus )
  );

  id_remap i_id_remap (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .slv     ( cut_bus ),
    .mst     ( mem_bus )
  );

  cdc_gray_src i_cdc_gray_src (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .slv        ( mem_bus    ),
    .req_wptr_o ( req_wptr_o ),
    .req_fifo_o ( req_fifo_o ),
    .req_rptr_i ( req_rptr_i ),
    .rsp_wptr_i ( rsp_wptr_i ),
    .rsp_fifo_i ( rsp_fifo_i ),
    .rsp_rptr_o ( rsp_rptr_o )
  );

endmodule

// ==== tb_cluster_mem_wrap.sv ====
`timescale 1ns/1ps

module tb_cluster_mem_wrap
  import mem_bus_pkg::*;
();

  localparam int ClkPeriod      = 100;
  localparam int NumReq         = 200;
  localparam int WatchdogCycles = 400 * 40;
  localparam int ErrAddrBit     = 8;
  localparam int Seed           = 59;

  logic                    clk_i;
  logic                    reset_i;
  logic     [NumPorts-1:0] req_valid;
  logic     [NumPorts-1:0] req_we;
  addr_t    [NumPorts-1:0] req_addr;
  data_t    [NumPorts-1:0] req_wdata;
  port_id_t [NumPorts-1:0] req_id;
  logic     [NumPorts-1:0] req_ready_o;
  logic     [NumPorts-1:0] rsp_valid_o;
  logic     [NumPorts-1:0] rsp_err_o;
  data_t    [NumPorts-1:0] rsp_rdata_o;
  port_id_t [NumPorts-1:0] rsp_id_o;
  logic     [NumPorts-1:0] rsp_ready;
  ptr_t                    req_wptr_o;
  req_fifo_t               req_fifo_o;
  ptr_t                    req_rptr;
  ptr_t                    rsp_wptr;
  rsp_fifo_t               rsp_fifo;
  ptr_t                    rsp_rptr_o;

  // Scoreboard state
  int           errors;
  int           checks;
  int           cyc;
  int           rsp_done;
  int           sent [NumPorts];
  int           gap [NumPorts];
  int           last_port;
  logic         other_waited;
  int           first_cyc;
  int           seed_val;
  // {port, id, we, addr, wdata} in acceptance order
  logic [67:0]  acc_q [$];
  // {id, err, rdata} per port
  logic [34:0]  exp0_q [$];
  logic [34:0]  exp1_q [$];
  data_t        ref_mem [16];

  // Far-side model state
  data_t        far_mem [16];
  ptr_t         far_rbin;
  ptr_t         far_wbin;
  ptr_t         wptr_s1;
  ptr_t         wptr_s2;
  ptr_t         rptr_s1;
  ptr_t         rptr_s2;
  int           delay;
  logic         stall;

  cluster_mem_wrap uut (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_valid_i ( req_valid   ),
    .req_we_i    ( req_we      ),
    .req_addr_i  ( req_addr    ),
    .req_wdata_i ( req_wdata   ),
    .req_id_i    ( req_id      ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_ready_i ( rsp_ready   ),
    .req_wptr_o  ( req_wptr_o  ),
    .req_fifo_o  ( req_fifo_o  ),
    .req_rptr_i  ( req_rptr    ),
    .rsp_wptr_i  ( rsp_wptr    ),
    .rsp_fifo_i  ( rsp_fifo    ),
    .rsp_rptr_o  ( rsp_rptr_o  )
  );

  function automatic ptr_t gray_of(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t bin_of(input ptr_t gray);
    ptr_t bin;
    bin[LogDepth] = gray[LogDepth];
    for (int i = LogDepth - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors = errors + 1;
    end
  endtask

  // ------------------------------
  // Initiator stimulus
  // ------------------------------
  task new_request(input int p);
    logic       err;
    logic [3:0] idx;
    err = ($urandom % 8) == 0;
    idx = 4'($urandom % 16);
    req_valid[p] <= 1'b1;
    req_we[p]    <= 1'($urandom % 2);
    req_addr[p]  <= (32'(err) << ErrAddrBit) | (32'(idx) << 2);
    req_wdata[p] <= $urandom;
    req_id[p]    <= port_id_t'($urandom % 4);
  endtask

  task step_port(input int p);
    if (req_valid[p] && req_ready_o[p]) begin
      // Cut register plus two FIFO entries is all the storage in flight
      if (acc_q.size() >= 3) begin
        $display("Port %0d accepted a request while the path was full at %0t ns", p, $time);
        errors = errors + 1;
      end
      if (last_port == p && other_waited) begin
        $display("Port %0d accepted twice in a row while the other waited at %0t ns",
                 p, $time);
        errors = errors + 1;
      end
      other_waited = req_valid[1-p];
      last_port    = p;
      acc_q.push_back({1'(p), req_id[p], req_we[p], req_addr[p], req_wdata[p]});
      if (first_cyc < 0) begin
        first_cyc = cyc;
      end
      sent[p]      = sent[p] + 1;
      gap[p]       = $urandom % 4;
      req_valid[p] <= 1'b0;
      if (gap[p] == 0 && sent[p] < NumReq) begin
        new_request(p);
      end
    end else if (!req_valid[p] && sent[p] < NumReq) begin
      if (gap[p] != 0) begin
        gap[p] = gap[p] - 1;
      end else begin
        new_request(p);
      end
    end
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (!reset_i) begin
      // First request on an idle bus reaches the crossing two edges later
      if (first_cyc >= 0 && cyc == first_cyc + 1) begin
        compare("req_wptr_o", 32'(req_wptr_o), 32'd0);
      end
      if (first_cyc >= 0 && cyc == first_cyc + 2 && req_wptr_o == '0) begin
        $display("req_wptr_o did not move two edges after the first request at %0t ns",
                 $time);
        errors = errors + 1;
      end
      step_port(0);
      step_port(1);
    end
  end

  // ------------------------------
  // Response checks
  // ------------------------------
  task check_response(input int p);
    logic [34:0] exp;
    if (rsp_valid_o[p] && rsp_ready[p]) begin
      rsp_done = rsp_done + 1;
      if ((p == 0 && exp0_q.size() == 0) || (p == 1 && exp1_q.size() == 0)) begin
        $display("Response on port %0d with nothing outstanding at %0t ns", p, $time);
        errors = errors + 1;
      end else begin
        if (p == 0) begin
          exp = exp0_q.pop_front();
        end else begin
          exp = exp1_q.pop_front();
        end
        compare($sformatf("rsp_id_o[%0d]", p), 32'(rsp_id_o[p]), 32'(exp[34:33]));
        compare($sformatf("rsp_err_o[%0d]", p), 32'(rsp_err_o[p]), 32'(exp[32]));
        compare($sformatf("rsp_rdata_o[%0d]", p), rsp_rdata_o[p], exp[31:0]);
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      rsp_ready <= '0;
    end else begin
      check_response(0);
      check_response(1);
      rsp_ready[0] <= ($urandom % 4) != 0;
      rsp_ready[1] <= ($urandom % 4) != 0;
    end
  end

  // ------------------------------
  // Far-side memory model
  // ------------------------------
  assign stall = (cyc % 500) >= 440;

  task serve_request;
    req_entry_t  ent;
    addr_t       e_addr;
    data_t       e_wdata;
    logic        e_we;
    mem_id_t     e_id;
    logic        e_err;
    data_t       far_rdata;
    logic [67:0] acc;
    logic        a_err;
    data_t       exp_rdata;
    int          rsp_base;
    ent      = req_fifo_o[(far_rbin[0] ? ReqBits : 0) +: ReqBits];
    {e_addr, e_wdata, e_we, e_id} = ent;
    e_err     = e_addr[ErrAddrBit];
    if (!e_err && e_we) begin
      far_mem[e_addr[5:2]] = e_wdata;
    end
    far_rdata = (e_err || e_we) ? '0 : far_mem[e_addr[5:2]];
    rsp_base  = far_wbin[0] ? RspBits : 0;
    rsp_fifo[rsp_base +: RspBits] <= {far_rdata, e_err, e_id};
    if (acc_q.size() == 0) begin
      $display("Memory side received a request that no port issued at %0t ns", $time);
      errors = errors + 1;
    end else begin
      acc = acc_q.pop_front();
      compare("req_fifo_o addr", e_addr, acc[63:32]);
      compare("req_fifo_o wdata", e_wdata, acc[31:0]);
      compare("req_fifo_o we", 32'(e_we), 32'(acc[64]));
      // Reference view of memory in crossing order
      a_err     = acc[32+ErrAddrBit];
      exp_rdata = (a_err || acc[64]) ? '0 : ref_mem[acc[37:34]];
      if (!a_err && acc[64]) begin
        ref_mem[acc[37:34]] = acc[31:0];
      end
      if (acc[67] == 1'b0) begin
        exp0_q.push_back({acc[66:65], a_err, exp_rdata});
      end else begin
        exp1_q.push_back({acc[66:65], a_err, exp_rdata});
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      wptr_s1  <= '0;
      wptr_s2  <= '0;
      rptr_s1  <= '0;
      rptr_s2  <= '0;
      req_rptr <= '0;
      rsp_wptr <= '0;
      far_rbin = '0;
      far_wbin = '0;
      delay    = 0;
    end else begin
      wptr_s1 <= req_wptr_o;
      wptr_s2 <= wptr_s1;
      rptr_s1 <= rsp_rptr_o;
      rptr_s2 <= rptr_s1;
      if (ptr_t'(bin_of(req_wptr_o) - far_rbin) > 2) begin
        $display("req_wptr_o ran more than two entries ahead at %0t ns", $time);
        errors = errors + 1;
      end
      if (delay != 0) begin
        delay = delay - 1;
      end else if (!stall && wptr_s2 != req_rptr &&
                   ptr_t'(far_wbin - bin_of(rptr_s2)) != 2) begin
        serve_request();
        far_rbin = far_rbin + 1'b1;
        far_wbin = far_wbin + 1'b1;
        req_rptr <= gray_of(far_rbin);
        rsp_wptr <= gray_of(far_wbin);
        delay    = $urandom % 4;
      end
    end
  end

  // ------------------------------
  // Clock, reset and run control
  // ------------------------------
  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired with %0d of %0d responses, checks %0d, errors %0d",
             rsp_done, 2 * NumReq, checks, errors);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seed_val     = $urandom(Seed);
    errors       = 0;
    checks       = 0;
    cyc          = 0;
    rsp_done     = 0;
    last_port    = -1;
    other_waited = 1'b0;
    first_cyc    = -1;
    for (int p = 0; p < NumPorts; p++) begin
      sent[p] = 0;
      gap[p]  = 0;
    end
    for (int i = 0; i < 16; i++) begin
      ref_mem[i] = '0;
      far_mem[i] = '0;
    end
    reset_i   = 1'b1;
    req_valid = '0;
    req_we    = '0;
    req_addr  = '0;
    req_wdata = '0;
    req_id    = '0;
    rsp_ready = '0;
    req_rptr  = '0;
    rsp_wptr  = '0;
    rsp_fifo  = '0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    compare("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    compare("req_ready_o", 32'(req_ready_o), 32'd0);
    compare("req_wptr_o", 32'(req_wptr_o), 32'd0);
    compare("rsp_rptr_o", 32'(rsp_rptr_o), 32'd0);
    wait (rsp_done == 2 * NumReq);
    repeat (20) @(posedge clk_i);
    if (acc_q.size() != 0 || exp0_q.size() != 0 || exp1_q.size() != 0) begin
      $display("Requests left without a response at the end of the run");
      errors = errors + 1;
    end
    $display("Responses %0d, checks %0d, errors %0d", rsp_done, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
mem_bus_pkg.sv
mem_bus_if.sv
port_arbiter.sv
bus_cut.sv
id_remap.sv
cdc_gray_src.sv
cluster_mem_wrap.sv
tb_cluster_mem_wrap.sv

// ==== Bender.yml ====
package:
  name: cluster_mem_wrap

sources:
  - files:
      - mem_bus_pkg.sv
      - mem_bus_if.sv
      - port_arbiter.sv
      - bus_cut.sv
      - id_remap.sv
      - cdc_gray_src.sv
      - cluster_mem_wrap.sv
  - target: test
    files:
      - tb_cluster_mem_wrap.sv
